// ==== list.f ====
+incdir+logic
logic/calc_op_pkg.sv
logic/fixed_point_pkg.sv
logic/fixed_alu.sv
logic/operation_sequencer.sv
logic/operand_stack.sv
logic/expr_eval_top.sv
verification/expr_eval_tb.sv

// ==== logic/calc_op_pkg.sv ====
`default_nettype none

package calc_op_pkg;

    // stack slot index width, enough for up to 8 slots
    localparam int INDEX_W = 3;

    // stack instruction opcodes
    typedef enum logic [2:0] {
        op_nop   = 3'b000,
        op_load1 = 3'b001,
        op_load2 = 3'b010,
        op_add   = 3'b011,
        op_mult  = 3'b100,
        op_neg   = 3'b101,
        op_abs   = 3'b110,
        op_halt  = 3'b111
    } calc_opcode_e;

    // one program word, 12 bits
    // index1 and index2 are sources (or load targets), index3 is the result slot
    typedef struct packed {
        calc_opcode_e       opcode;
        logic [INDEX_W-1:0] index1;
        logic [INDEX_W-1:0] index2;
        logic [INDEX_W-1:0] index3;
    } calc_instr_t;

endpackage

`default_nettype wire

// ==== logic/calc_program.svh ====
`ifndef CALC_PROGRAM_SVH
`define CALC_PROGRAM_SVH

// fixed program, needs calc_op_pkg visible at the point of inclusion
// result in slot 0 is abs(x - x*y) + y

localparam int PROGRAM_LEN = 10;

// fields in order: opcode, index1, index2, index3
localparam calc_instr_t PROGRAM_TABLE [PROGRAM_LEN] = '{
    // slot 1 gets x
    '{op_load1, 3'd1, 3'd0, 3'd0},
    // slot 2 gets y
    '{op_load2, 3'd0, 3'd2, 3'd0},
    // slot 3 gets x*y
    '{op_mult,  3'd1, 3'd2, 3'd3},
    // slot 4 gets -(x*y)
    '{op_neg,   3'd3, 3'd0, 3'd4},
    // slot 0 gets x - x*y
    '{op_add,   3'd4, 3'd1, 3'd0},
    // slot 0 gets its own absolute value
    '{op_abs,   3'd0, 3'd0, 3'd0},
    // slot 0 gets slot 0 + y
    '{op_add,   3'd0, 3'd2, 3'd0},
    '{op_nop,   3'd0, 3'd0, 3'd0},
    // end of program, second halt is padding
    '{op_halt,  3'd0, 3'd0, 3'd0},
    '{op_halt,  3'd0, 3'd0, 3'd0}
};

`endif

// ==== logic/expr_eval_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module expr_eval_top #(
    parameter int N           = 32,
    parameter int Q           = 16,
    parameter int STACK_DEPTH = 5
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  apply,
    input  wire logic [N-1:0]          value,
    output logic [N-1:0]               out,
    output fixed_point_pkg::fx_flags_t flags,
    output logic                       done
);
    import calc_op_pkg::*;
    import fixed_point_pkg::*;

    // sequencer to stack
    calc_instr_t  instr;
    logic         instr_valid;
    logic [N-1:0] instr_value;

    // stack to alu and back
    calc_opcode_e alu_op;
    logic [N-1:0] alu_a;
    logic [N-1:0] alu_b;
    logic [N-1:0] alu_result;
    fx_flags_t    alu_flags;

    // issues one program word per apply
    operation_sequencer #(
        .N(N)
    ) u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .apply      (apply),
        .value      (value),
        .instr      (instr),
        .instr_valid(instr_valid),
        .instr_value(instr_value),
        .done       (done)
    );

    // slots, load path and execute pipeline
    operand_stack #(
        .N          (N),
        .STACK_DEPTH(STACK_DEPTH)
    ) u_stack (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .instr_valid(instr_valid),
        .instr_value(instr_value),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .out        (out),
        .flags      (flags)
    );

    // combinational saturating arithmetic
    fixed_alu #(
        .N(N),
        .Q(Q)
    ) u_alu (
        .op    (alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .result(alu_result),
        .flags (alu_flags)
    );

endmodule

`default_nettype wire

// ==== logic/fixed_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module fixed_alu #(
    parameter int N = 32,
    parameter int Q = 16
) (
    input  wire calc_op_pkg::calc_opcode_e op,
    input  wire logic [N-1:0]              a,
    input  wire logic [N-1:0]              b,
    output logic [N-1:0]                   result,
    output fixed_point_pkg::fx_flags_t     flags
);
    import calc_op_pkg::*;
    import fixed_point_pkg::*;

    // range limits of the signed format
    localparam logic [N-1:0] MAX_VAL = {1'b0, {(N-1){1'b1}}};
    localparam logic [N-1:0] MIN_VAL = {1'b1, {(N-1){1'b0}}};
    // half an lsb of the result, placed below the Q fraction bits of the product
    localparam logic [2*N-1:0] HALF_LSB = FX_ROUND_NEAREST ? ((2*N)'(1) << (Q-1)) : '0;

    // add with one guard bit
    logic [N:0] sum;
    logic       add_ovf;

    // full product, rounding and rescale
    logic signed [2*N-1:0] product;
    logic signed [2*N-1:0] rounded;
    logic signed [2*N-1:0] scaled;
    logic [N:0]            scaled_top;
    logic                  mul_ovf;

    // negate, most negative value has no positive twin
    logic         a_is_min;
    logic [N-1:0] neg_val;

    logic ovf;

    assign sum     = {a[N-1], a} + {b[N-1], b};
    // guard bit disagrees with sign bit only on overflow
    assign add_ovf = sum[N] ^ sum[N-1];

    assign product    = $signed(a) * $signed(b);
    assign rounded    = product + $signed(HALF_LSB);
    assign scaled     = rounded >>> Q;
    // result fits when all bits above the new sign bit copy it
    assign scaled_top = scaled[2*N-1:N-1];
    assign mul_ovf    = !((&scaled_top) || (~|scaled_top));

    assign a_is_min = (a == MIN_VAL);
    assign neg_val  = a_is_min ? MAX_VAL : ('0 - a);

    always_comb begin
        result = '0;
        ovf    = 1'b0;
        case (op)
            op_add: begin
                // clamp toward the sign of the true sum
                result = add_ovf ? (sum[N] ? MIN_VAL : MAX_VAL) : sum[N-1:0];
                ovf    = add_ovf;
            end
            op_mult: begin
                result = mul_ovf ? (scaled[2*N-1] ? MIN_VAL : MAX_VAL) : scaled[N-1:0];
                ovf    = mul_ovf;
            end
            op_neg: begin
                result = neg_val;
                ovf    = a_is_min;
            end
            op_abs: begin
                result = a[N-1] ? neg_val : a;
                ovf    = a_is_min;
            end
            // nop, loads and halt produce nothing
            default: begin
                result = '0;
                ovf    = 1'b0;
            end
        endcase
        flags.overflow = ovf;
        flags.negative = result[N-1];
    end

endmodule

`default_nettype wire

// ==== logic/fixed_point_pkg.sv ====
`default_nettype none

package fixed_point_pkg;

    // status of one alu result
    // overflow marks a clamp to the range limits
    // negative is the sign bit of the result
    typedef struct packed {
        logic overflow;
        logic negative;
    } fx_flags_t;

    // multiply rounding mode
    // set: add half an lsb before dropping the fraction bits
    // clear: plain truncation toward minus infinity
    localparam logic FX_ROUND_NEAREST = 1'b1;

    // add, multiply, negate and abs always saturate in this format,
    // there is no wrapping mode

endpackage

`default_nettype wire

// ==== logic/operand_stack.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_stack #(
    parameter int N           = 32,
    parameter int STACK_DEPTH = 5
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire calc_op_pkg::calc_instr_t   instr,
    input  wire logic                       instr_valid,
    input  wire logic [N-1:0]               instr_value,
    input  wire logic [N-1:0]               alu_result,
    input  wire fixed_point_pkg::fx_flags_t alu_flags,
    output calc_op_pkg::calc_opcode_e       alu_op,
    output logic [N-1:0]                    alu_a,
    output logic [N-1:0]                    alu_b,
    output logic [N-1:0]                    out,
    output fixed_point_pkg::fx_flags_t      flags
);
    import calc_op_pkg::*;
    import fixed_point_pkg::*;

    // slot storage, slot 0 is the visible result
    logic [N-1:0] slots [STACK_DEPTH];

    // stage 2 state, one arithmetic op in flight
    logic               ex_valid;
    calc_opcode_e       ex_op;
    logic [INDEX_W-1:0] ex_target;
    logic [N-1:0]       ex_a;
    logic [N-1:0]       ex_b;

    // stage 1 decode and operand fetch
    logic         issue_arith;
    logic [N-1:0] slot_a;
    logic [N-1:0] slot_b;
    logic [N-1:0] rd_a;
    logic [N-1:0] rd_b;

    // indexes past the last slot read as zero and drop writes
    function automatic logic in_range(input logic [INDEX_W-1:0] idx);
        return int'(idx) < STACK_DEPTH;
    endfunction

    assign issue_arith = instr_valid &&
                         (instr.opcode inside {op_add, op_mult, op_neg, op_abs});

    always_comb begin
        slot_a = '0;
        slot_b = '0;
        if (in_range(instr.index1)) begin
            slot_a = slots[instr.index1];
        end
        if (in_range(instr.index2)) begin
            slot_b = slots[instr.index2];
        end
    end

    // forward the result that is written at this same edge
    assign rd_a = (ex_valid && ex_target == instr.index1) ? alu_result : slot_a;
    assign rd_b = (ex_valid && ex_target == instr.index2) ? alu_result : slot_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STACK_DEPTH; i++) begin
                slots[i] <= '0;
            end
            ex_valid  <= 1'b0;
            ex_op     <= op_nop;
            ex_target <= '0;
            flags     <= '0;
        end else begin
            // load path, value goes straight into its slot
            if (instr_valid && instr.opcode == op_load1 && in_range(instr.index1)) begin
                slots[instr.index1] <= instr_value;
            end
            if (instr_valid && instr.opcode == op_load2 && in_range(instr.index2)) begin
                slots[instr.index2] <= instr_value;
            end
            // stage 2 writeback
            if (ex_valid && in_range(ex_target)) begin
                slots[ex_target] <= alu_result;
            end
            if (ex_valid) begin
                // overflow sticks, sign tracks the latest result
                flags.overflow <= flags.overflow | alu_flags.overflow;
                flags.negative <= alu_flags.negative;
            end
            // stage 1 to stage 2
            ex_valid <= issue_arith;
            if (issue_arith) begin
                ex_op     <= instr.opcode;
                ex_target <= instr.index3;
            end
        end
    end

    // operand registers feeding the alu
    always_ff @(posedge clk) begin
        if (issue_arith) begin
            ex_a <= rd_a;
            ex_b <= rd_b;
        end
    end

    assign alu_op = ex_op;
    assign alu_a  = ex_a;
    assign alu_b  = ex_b;
    assign out    = slots[0];

endmodule

`default_nettype wire

// ==== logic/operation_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module operation_sequencer #(
    parameter int N = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              apply,
    input  wire logic [N-1:0]      value,
    output calc_op_pkg::calc_instr_t instr,
    output logic                   instr_valid,
    output logic [N-1:0]           instr_value,
    output logic                   done
);
    import calc_op_pkg::*;

`include "calc_program.svh"

    localparam int PC_W = $clog2(PROGRAM_LEN);

    // program counter into the constant table
    logic [PC_W-1:0] pc;
    // table word at the counter
    calc_instr_t     current;
    // apply only counts before halt
    logic            issue;

    assign current = PROGRAM_TABLE[pc];
    assign issue   = apply && !done;

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= '0;
            instr_valid <= 1'b0;
            done        <= 1'b0;
        end else begin
            // valid is a one-cycle pulse per accepted apply
            instr_valid <= issue;
            if (issue) begin
                // counter parks on halt, done stays until reset
                if (current.opcode == op_halt) begin
                    done <= 1'b1;
                end else begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    // issued word and the value sampled with it
    always_ff @(posedge clk) begin
        if (issue) begin
            instr       <= current;
            instr_value <= value;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, and decide by the log contents
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module expr_eval_tb -f list.f -o expr_eval_sim \
    && ./obj_dir/expr_eval_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL"; exit 1; }

// ==== verification/expr_eval_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module expr_eval_tb;
    import calc_op_pkg::*;
    import fixed_point_pkg::*;

    // the sequencer pulls the same table into this compilation unit first
`undef CALC_PROGRAM_SVH
`include "calc_program.svh"

    localparam int N = 32;
    localparam int Q = 16;
    localparam longint MAX_L = (64'sd1 <<< (N - 1)) - 1;
    localparam longint MIN_L = -(64'sd1 <<< (N - 1));
    localparam int DONE_TIMEOUT = 40;

    logic         clk;
    logic         rst;
    logic         apply;
    logic [N-1:0] value;
    logic [N-1:0] out;
    fx_flags_t    flags;
    logic         done;

    int          errors;
    int          checks;
    logic [15:0] lfsr_state;

    // values driven with each apply and the reference model state
    logic [N-1:0] step_value [PROGRAM_LEN];
    logic [N-1:0] m_slots [8];
    logic         m_ovf;
    logic         m_neg;
    int           halt_step;

    expr_eval_top u_dut (
        .clk  (clk),
        .rst  (rst),
        .apply(apply),
        .value(value),
        .out  (out),
        .flags(flags),
        .done (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic random_bits(input int n, output logic [N-1:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[N-2:0], lfsr_state[0]};
        end
    endtask

    // small q16 operand of roughly -8.0 to +8.0
    task automatic random_operand(output logic [N-1:0] v);
        logic [N-1:0] raw;
        random_bits(20, raw);
        v = {{(N - 20){raw[19]}}, raw[19:0]};
    endtask

    // exact result in 64 bits and then a clamp to the n-bit range
    task automatic model_op(input calc_opcode_e op, input logic [N-1:0] a,
                            input logic [N-1:0] b, output logic [N-1:0] r, output logic ovf);
        longint sa;
        longint sb;
        longint full;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            op_add: full = sa + sb;
            op_mult: begin
                full = sa * sb;
                // round to nearest before the fraction bits drop
                if (FX_ROUND_NEAREST)
                    full = full + (64'sd1 <<< (Q - 1));
                full = full >>> Q;
            end
            op_neg: full = -sa;
            default: full = (sa < 0) ? -sa : sa;
        endcase
        ovf = (full > MAX_L) || (full < MIN_L);
        r = (full > MAX_L) ? N'(MAX_L) : ((full < MIN_L) ? N'(MIN_L) : N'(full));
    endtask

    // walk the program in order without any pipeline
    task automatic run_model();
        calc_instr_t  ins;
        logic [N-1:0] r;
        logic         ovf;
        for (int i = 0; i < 8; i++)
            m_slots[i] = '0;
        m_ovf = 1'b0;
        m_neg = 1'b0;
        halt_step = -1;
        for (int k = 0; k < PROGRAM_LEN && halt_step < 0; k++) begin
            ins = PROGRAM_TABLE[k];
            case (ins.opcode)
                op_load1: m_slots[ins.index1] = step_value[k];
                op_load2: m_slots[ins.index2] = step_value[k];
                op_add, op_mult, op_neg, op_abs: begin
                    model_op(ins.opcode, m_slots[ins.index1], m_slots[ins.index2], r, ovf);
                    m_slots[ins.index3] = r;
                    m_ovf = m_ovf | ovf;
                    m_neg = r[N-1];
                end
                op_halt: halt_step = k;
                default: ;
            endcase
        end
    endtask

    task automatic check_value(input string name, input logic [N-1:0] got,
                               input logic [N-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst   = 1'b1;
        apply = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_value("out", out, '0);
        check_value("flags", flags, '0);
        check_value("done", done, 1'b0);
    endtask

    // one apply per program step with gap idle cycles after each
    task automatic drive_program(input int gap);
        for (int k = 0; k <= halt_step; k++) begin
            apply = 1'b1;
            value = step_value[k];
            if (k == halt_step)
                check_value("done", done, 1'b0);
            @(negedge clk);
            apply = 1'b0;
            // halt issues in the next cycle and done follows at once
            if (k == halt_step)
                check_value("done", done, 1'b1);
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        assert (done) else begin
            $display("timeout: done never rose after the last apply");
            errors++;
        end
    endtask

    task automatic run_case(input logic [N-1:0] x, input logic [N-1:0] y, input int gap);
        logic [N-1:0] late;
        step_value[0] = x;
        step_value[1] = y;
        // values sent with non-load steps must be ignored
        for (int k = 2; k < PROGRAM_LEN; k++)
            random_bits(N, step_value[k]);
        run_model();
        reset_dut();
        drive_program(gap);
        wait_for_done();
        // let the last writeback drain
        repeat (2) @(negedge clk);
        check_value("out", out, m_slots[0]);
        check_value("flags.overflow", flags.overflow, m_ovf);
        check_value("flags.negative", flags.negative, m_neg);
        // a whole program of applies after halt changes nothing
        repeat (PROGRAM_LEN) begin
            random_bits(N, late);
            apply = 1'b1;
            value = late;
            @(negedge clk);
            apply = 1'b0;
            @(negedge clk);
        end
        check_value("out", out, m_slots[0]);
        check_value("done", done, 1'b1);
        check_value("flags.overflow", flags.overflow, m_ovf);
    endtask

    initial begin
        logic [N-1:0] x;
        logic [N-1:0] y;
        errors = 0;
        checks = 0;
        lfsr_state = 16'd85;
        rst = 1'b1;
        apply = 1'b0;
        value = '0;
        // gapped and back-to-back runs on the same operands
        for (int i = 0; i < 6; i++) begin
            random_operand(x);
            random_operand(y);
            run_case(x, y, 3);
            run_case(x, y, 0);
        end
        // product far above the range and then far below
        run_case(32'h7fff_0000, 32'h0010_0000, 1);
        check_value("flags.overflow", flags.overflow, 1'b1);
        run_case(32'h7fff_0000, 32'hfff0_0000, 0);
        check_value("flags.overflow", flags.overflow, 1'b1);
        // product clamps low and the final sum clamps to the largest value
        run_case(32'hfff0_0000, 32'h7fff_0000, 0);
        check_value("out", out, N'(MAX_L));
        check_value("flags.overflow", flags.overflow, 1'b1);
        // fresh values after the reset that clears the sticky flag
        random_operand(x);
        random_operand(y);
        run_case(x, y, 2);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
